// File: Makefile
# Verilator simulation of the memory server

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_mem_server \
		-Mdir obj_dir -f all.f
	@out=$$(./obj_dir/Vtb_mem_server); \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// File: all.f
common/mem_srv_pkg.sv
common/mem_port_if.sv
isa_fetch/isa_fetch.sv
data_cmd/data_cmd.sv
source/port_combine.sv
source/mem_server.sv
tb/tb_mem_server.sv

// File: common/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;

    import mem_srv_pkg::*;

    // Engine side requests
    logic  req;
    logic  rd;
    logic  wr;
    addr_t addr;
    data_t wdata;
    // Outgoing stream toward the chip
    data_t out_dat;
    logic  out_vld;
    // Incoming stream acceptance
    logic  in_rdy;
    // Combiner side answers
    logic  gnt;
    // Registered store data, one cycle after rd
    data_t rdata;

    modport engine (
        output req, rd, wr, addr, wdata, out_dat, out_vld, in_rdy,
        input  gnt, rdata
    );

    modport combiner (
        input  req, rd, wr, addr, wdata, out_dat, out_vld, in_rdy,
        output gnt, rdata
    );

endinterface

`default_nettype wire

// File: common/mem_srv_pkg.sv
`default_nettype none

package mem_srv_pkg;

    // ==========================================================
    // Sizes
    // ==========================================================
    // One store word, also the width of the chip data port
    localparam int DATA_W    = 64;
    // Word address into a 1024-word store
    localparam int ADDR_W    = 10;
    // Burst length field of a command
    localparam int LEN_W     = 8;
    // Execution units that fetch instructions
    localparam int NUM_UNITS = 4;
    localparam int UNIT_W    = 2;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    // Zero encodes a burst of 256 words
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [UNIT_W-1:0] unit_t;
    // Burst word counter, one bit wider so 256 fits
    typedef logic [LEN_W:0]    cnt_t;

    // Instruction region start of each unit, index 0 on the right
    localparam addr_t [NUM_UNITS-1:0] ISA_BASE = {
        addr_t'(192), addr_t'(128), addr_t'(64), addr_t'(0)
    };

    // ==========================================================
    // Command word layout
    // ==========================================================
    // Set for a write burst into the store
    localparam int CMD_DIR_BIT  = 0;
    localparam int CMD_ADDR_LSB = 1;
    localparam int CMD_LEN_LSB  = CMD_ADDR_LSB + ADDR_W;

    // ==========================================================
    // State machines
    // ==========================================================
    typedef enum logic {FETCH_IDLE, FETCH_RUN} fetch_state_t;
    typedef enum logic [1:0] {CMD_IDLE, CMD_WAIT, CMD_READ, CMD_WRITE} cmd_state_t;

endpackage

`default_nettype wire

// File: data_cmd/data_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module data_cmd (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_vld,
    input  logic               acc_dat_vld,
    input  logic               acc_rdy,
    input  mem_srv_pkg::data_t acc_dat,
    mem_port_if.engine         port
);

    import mem_srv_pkg::*;

    cmd_state_t state;
    logic       req;
    // Current store address of the burst
    addr_t      cur;
    // Words still to transfer with the chip
    cnt_t       xfer_left;
    // Reads still to issue in a read burst
    cnt_t       rd_left;
    logic       rd_pend;
    logic       hold_vld;
    data_t      hold_dat;
    logic       take;
    logic       issue;
    logic       in_rdy;
    logic       cmd_wr;
    addr_t      cmd_addr;
    len_t       cmd_len;
    cnt_t       cmd_cnt;

    // ==========================================================
    // Command decode
    // ==========================================================
    assign cmd_wr   = acc_dat[CMD_DIR_BIT];
    assign cmd_addr = acc_dat[CMD_ADDR_LSB +: ADDR_W];
    assign cmd_len  = acc_dat[CMD_LEN_LSB +: LEN_W];
    // Zero length means a full 256-word burst
    assign cmd_cnt  = (cmd_len == '0) ? cnt_t'(1 << LEN_W) : cnt_t'(cmd_len);

    // Command word and write data both come in on acc_dat
    assign in_rdy = (state == CMD_WAIT) || (state == CMD_WRITE);
    assign take   = hold_vld & acc_rdy;
    assign issue  = (state == CMD_READ) && (rd_left != '0) && !rd_pend
                    && (!hold_vld || take);

    // ==========================================================
    // Burst FSM
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CMD_IDLE;
            req       <= 1'b0;
            cur       <= '0;
            xfer_left <= '0;
            rd_left   <= '0;
        end else begin
            case (state)
                CMD_IDLE: begin
                    if (!req) begin
                        if (cmd_vld) begin
                            req <= 1'b1;
                        end
                    end else if (port.gnt) begin
                        state <= CMD_WAIT;
                    end
                end
                CMD_WAIT: begin
                    if (acc_dat_vld) begin
                        cur       <= cmd_addr;
                        xfer_left <= cmd_cnt;
                        rd_left   <= cmd_cnt;
                        state     <= cmd_wr ? CMD_WRITE : CMD_READ;
                    end
                end
                CMD_WRITE: begin
                    if (acc_dat_vld) begin
                        cur       <= cur + addr_t'(1);
                        xfer_left <= xfer_left - cnt_t'(1);
                        if (xfer_left == cnt_t'(1)) begin
                            state <= CMD_IDLE;
                            req   <= 1'b0;
                        end
                    end
                end
                CMD_READ: begin
                    if (issue) begin
                        cur     <= cur + addr_t'(1);
                        rd_left <= rd_left - cnt_t'(1);
                    end
                    // Done when the last word has left the holding register
                    if (take) begin
                        xfer_left <= xfer_left - cnt_t'(1);
                        if (xfer_left == cnt_t'(1)) begin
                            state <= CMD_IDLE;
                            req   <= 1'b0;
                        end
                    end
                end
                default: state <= CMD_IDLE;
            endcase
        end
    end

    // ==========================================================
    // Read pipeline
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend  <= 1'b0;
            hold_vld <= 1'b0;
        end else begin
            rd_pend <= issue;
            // Slot is free or leaving whenever a read returns
            if (rd_pend) begin
                hold_vld <= 1'b1;
            end else if (take) begin
                hold_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend) begin
            hold_dat <= port.rdata;
        end
    end

    assign port.req     = req;
    assign port.rd      = issue;
    assign port.wr      = (state == CMD_WRITE) && acc_dat_vld;
    // Reads and writes both walk the same address
    assign port.addr    = cur;
    assign port.wdata   = acc_dat;
    assign port.out_dat = hold_dat;
    assign port.out_vld = hold_vld;
    assign port.in_rdy  = in_rdy;

endmodule

`default_nettype wire

// File: isa_fetch/isa_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module isa_fetch (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [mem_srv_pkg::NUM_UNITS-1:0] cfg_rdy,
    input  logic                              acc_rdy,
    output logic                              isa_vld,
    mem_port_if.engine                        port
);

    import mem_srv_pkg::*;

    fetch_state_t state;
    logic         req;
    unit_t        unit_sel;
    unit_t        unit_pick;
    logic         unit_live;
    logic         rd_pend;
    logic         hold_vld;
    data_t        hold_dat;
    logic         take;
    logic         issue;
    // Accepted words per unit, kept across sessions
    addr_t        rd_cnt [NUM_UNITS];

    // ==========================================================
    // Arbitration
    // ==========================================================
    // Lowest index wins, so scan downward
    always_comb begin
        unit_pick = '0;
        for (int i = NUM_UNITS - 1; i >= 0; i--) begin
            if (cfg_rdy[i]) begin
                unit_pick = unit_t'(i);
            end
        end
    end

    // Latched unit still wants instructions
    assign unit_live = cfg_rdy[unit_sel];
    // Held word leaves this cycle
    assign take      = hold_vld & acc_rdy;
    // One read in flight at most, and only into a free holding slot
    assign issue     = req & port.gnt & unit_live & ~rd_pend & (~hold_vld | take);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FETCH_IDLE;
            req      <= 1'b0;
            unit_sel <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (!req) begin
                        if (|cfg_rdy) begin
                            req      <= 1'b1;
                            unit_sel <= unit_pick;
                        end
                    end else if (!unit_live) begin
                        // Requester gave up before the grant came
                        req <= 1'b0;
                    end else if (port.gnt) begin
                        state <= FETCH_RUN;
                    end
                end
                FETCH_RUN: begin
                    // Session over once the unit drops its line
                    if (!unit_live) begin
                        state <= FETCH_IDLE;
                        req   <= 1'b0;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // ==========================================================
    // Read pipeline and holding register
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend  <= 1'b0;
            hold_vld <= 1'b0;
        end else if (state == FETCH_RUN && !unit_live) begin
            // Drop anything still held, it is read again next session
            rd_pend  <= 1'b0;
            hold_vld <= 1'b0;
        end else begin
            rd_pend <= issue;
            if (rd_pend) begin
                hold_vld <= 1'b1;
            end else if (take) begin
                hold_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend) begin
            hold_dat <= port.rdata;
        end
    end

    // Count only words the chip took
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                rd_cnt[i] <= '0;
            end
        end else if (take) begin
            rd_cnt[unit_sel] <= rd_cnt[unit_sel] + addr_t'(1);
        end
    end

    assign isa_vld = (state == FETCH_RUN);

    // Next word skips past one still waiting in the holding register
    assign port.addr    = ISA_BASE[unit_sel] + rd_cnt[unit_sel] + addr_t'(hold_vld);
    assign port.req     = req;
    assign port.rd      = issue;
    // Fetch never writes or accepts chip data
    assign port.wr      = 1'b0;
    assign port.wdata   = '0;
    assign port.in_rdy  = 1'b0;
    assign port.out_dat = hold_dat;
    assign port.out_vld = hold_vld;

endmodule

`default_nettype wire

// File: source/mem_server.sv
`timescale 1ns/1ps
`default_nettype none

module mem_server (
    input  logic                              clk,
    input  logic                              rst_n,
    // Instruction fetch requests, one per unit
    input  logic [mem_srv_pkg::NUM_UNITS-1:0] cfg_rdy,
    // Data command strobe
    input  logic                              cmd_vld,
    // Chip to server stream
    input  logic                              acc_dat_vld,
    input  mem_srv_pkg::data_t                acc_dat,
    output logic                              srv_rdy,
    // Server to chip stream
    input  logic                              acc_rdy,
    output logic                              srv_dat_vld,
    output mem_srv_pkg::data_t                srv_dat,
    // High while a fetch session owns the port
    output logic                              isa_vld
);

    // One link per engine into the combiner
    mem_port_if fetch_if ();
    mem_port_if data_if ();

    // ==========================================================
    // Engines
    // ==========================================================
    isa_fetch isa_fetch_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_rdy (cfg_rdy),
        .acc_rdy (acc_rdy),
        .isa_vld (isa_vld),
        .port    (fetch_if.engine)
    );

    data_cmd data_cmd_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_vld     (cmd_vld),
        .acc_dat_vld (acc_dat_vld),
        .acc_rdy     (acc_rdy),
        .acc_dat     (acc_dat),
        .port        (data_if.engine)
    );

    // Store owner and port steering
    port_combine port_combine_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch       (fetch_if.combiner),
        .data        (data_if.combiner),
        .srv_dat     (srv_dat),
        .srv_dat_vld (srv_dat_vld),
        .srv_rdy     (srv_rdy)
    );

endmodule

`default_nettype wire

// File: source/port_combine.sv
`timescale 1ns/1ps
`default_nettype none

module port_combine (
    input  logic               clk,
    input  logic               rst_n,
    mem_port_if.combiner       fetch,
    mem_port_if.combiner       data,
    output mem_srv_pkg::data_t srv_dat,
    output logic               srv_dat_vld,
    output logic               srv_rdy
);

    import mem_srv_pkg::*;

    // One-hot owner, both low when the port is free
    logic  gnt_fetch;
    logic  gnt_data;
    data_t store [2**ADDR_W];
    data_t rdata_q;
    logic  acc_rd;
    logic  acc_wr;
    addr_t acc_addr;
    data_t acc_wdata;

    // ==========================================================
    // Grant register
    // ==========================================================
    // Owner keeps the port until it drops req, then one idle cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_fetch <= 1'b0;
            gnt_data  <= 1'b0;
        end else if (gnt_fetch) begin
            if (!fetch.req) begin
                gnt_fetch <= 1'b0;
            end
        end else if (gnt_data) begin
            if (!data.req) begin
                gnt_data <= 1'b0;
            end
        end else if (fetch.req) begin
            // Fetch has priority on a free port
            gnt_fetch <= 1'b1;
        end else if (data.req) begin
            gnt_data <= 1'b1;
        end
    end

    assign fetch.gnt = gnt_fetch;
    assign data.gnt  = gnt_data;

    // ==========================================================
    // Store access
    // ==========================================================
    always_comb begin
        acc_rd    = 1'b0;
        acc_wr    = 1'b0;
        acc_addr  = data.addr;
        acc_wdata = data.wdata;
        if (gnt_fetch) begin
            acc_rd    = fetch.rd;
            acc_wr    = fetch.wr;
            acc_addr  = fetch.addr;
            acc_wdata = fetch.wdata;
        end else if (gnt_data) begin
            acc_rd = data.rd;
            acc_wr = data.wr;
        end
    end

    // Store comes up all zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**ADDR_W; i++) begin
                store[i] <= '0;
            end
        end else if (acc_wr) begin
            store[acc_addr] <= acc_wdata;
        end
    end

    // Synchronous read, result held until the next read
    always_ff @(posedge clk) begin
        if (acc_rd) begin
            rdata_q <= store[acc_addr];
        end
    end

    assign fetch.rdata = rdata_q;
    assign data.rdata  = rdata_q;

    // ==========================================================
    // Chip-facing stream
    // ==========================================================
    always_comb begin
        srv_dat     = '0;
        srv_dat_vld = 1'b0;
        srv_rdy     = 1'b0;
        if (gnt_fetch) begin
            srv_dat     = fetch.out_dat;
            srv_dat_vld = fetch.out_vld;
            srv_rdy     = fetch.in_rdy;
        end else if (gnt_data) begin
            srv_dat     = data.out_dat;
            srv_dat_vld = data.out_vld;
            srv_rdy     = data.in_rdy;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_mem_server.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_server;

    import mem_srv_pkg::*;

    // Cycles any single wait may take before the run is abandoned
    localparam int LIMIT = 2000;

    logic                 clk;
    logic                 rst_n;
    logic [NUM_UNITS-1:0] cfg_rdy;
    logic                 cmd_vld;
    logic                 acc_dat_vld;
    data_t                acc_dat;
    logic                 acc_rdy;
    logic                 srv_rdy;
    logic                 srv_dat_vld;
    data_t                srv_dat;
    logic                 isa_vld;

    // Reference copy of the store
    data_t ref_mem [2**ADDR_W];
    // Accepted fetch words per unit
    int    exp_cnt [NUM_UNITS];
    int    checks;
    int    errors;
    int    err_mark;

    mem_server mem_server_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_rdy     (cfg_rdy),
        .cmd_vld     (cmd_vld),
        .acc_dat_vld (acc_dat_vld),
        .acc_dat     (acc_dat),
        .srv_rdy     (srv_rdy),
        .acc_rdy     (acc_rdy),
        .srv_dat_vld (srv_dat_vld),
        .srv_dat     (srv_dat),
        .isa_vld     (isa_vld)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ============================================================
    // Concurrent checks
    // ============================================================
    // Stalled word from a data read must not move
    assert property (@(posedge clk) disable iff (!rst_n)
        srv_dat_vld && !acc_rdy && !isa_vld |=> srv_dat_vld && $stable(srv_dat))
        else begin
            errors++;
            $display("mismatch at %0t: srv_dat moved while stalled", $time);
        end

    // Stalled fetch word is either dropped at session end or left as it is
    assert property (@(posedge clk) disable iff (!rst_n)
        srv_dat_vld && !acc_rdy && isa_vld |=> !srv_dat_vld || $stable(srv_dat))
        else begin
            errors++;
            $display("mismatch at %0t: fetch word moved while stalled", $time);
        end

    // Everything quiet in reset
    assert property (@(posedge clk) !rst_n |-> !isa_vld && !srv_dat_vld && !srv_rdy)
        else begin
            errors++;
            $display("mismatch at %0t: outputs active in reset", $time);
        end

    // Fetch owns the port, so no chip data is accepted
    assert property (@(posedge clk) disable iff (!rst_n) isa_vld |-> !srv_rdy)
        else begin
            errors++;
            $display("mismatch at %0t: srv_rdy high during fetch", $time);
        end

    // ============================================================
    // Helpers
    // ============================================================
    task automatic abort(input string what);
        $display("timeout: %s", what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic check_word(input data_t got, input data_t exp, input string what);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("mismatch at %0t: %s", $time, what);
        end
    endtask

    task automatic report(input string name);
        if (errors == err_mark) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    function automatic data_t make_cmd(input logic wr, input addr_t a, input int n);
        data_t w;
        w = '0;
        w[0] = wr;
        w[1 +: ADDR_W] = a;
        w[1 + ADDR_W +: LEN_W] = len_t'(n);
        return w;
    endfunction

    // Unit regions sit 64 words apart
    function automatic addr_t fetch_addr(input int k);
        return addr_t'(k * 64 + exp_cnt[k]);
    endfunction

    function automatic data_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // Present a command word until the server takes it
    task automatic send_cmd(input logic wr, input addr_t a, input int n);
        int t;
        @(posedge clk);
        cmd_vld     <= 1'b1;
        acc_dat     <= make_cmd(wr, a, n);
        acc_dat_vld <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > LIMIT) abort("command word never accepted");
        end while (!srv_rdy);
        @(posedge clk);
        cmd_vld     <= 1'b0;
        acc_dat_vld <= wr;
    endtask

    task automatic write_burst(input addr_t a, input int n);
        int    sent;
        int    t;
        data_t w;
        send_cmd(1'b1, a, n);
        sent = 0;
        t = 0;
        w = rand_word();
        acc_dat <= w;
        while (sent < n) begin
            @(negedge clk);
            t++;
            if (t > LIMIT) abort("write burst stalled");
            if (srv_rdy) begin
                ref_mem[addr_t'(a + addr_t'(sent))] = w;
                sent++;
            end
            @(posedge clk);
            if (sent < n) begin
                w = rand_word();
                acc_dat <= w;
            end else begin
                acc_dat_vld <= 1'b0;
            end
        end
    endtask

    task automatic read_burst(input addr_t a, input int n);
        int got;
        int t;
        send_cmd(1'b0, a, n);
        got = 0;
        t = 0;
        while (got < n) begin
            @(negedge clk);
            t++;
            if (t > LIMIT) abort("read burst words missing");
            if (srv_dat_vld && acc_rdy) begin
                check_true(!isa_vld, "isa_vld high during data read");
                check_word(srv_dat, ref_mem[addr_t'(a + addr_t'(got))], "read word");
                got++;
            end
            @(posedge clk);
            acc_rdy <= (got < n) ? (($urandom % 4) != 0) : 1'b0;
        end
        // Nothing extra after the burst
        repeat (3) begin
            @(negedge clk);
            check_true(!srv_dat_vld, "extra word after read burst");
        end
    endtask

    task automatic fetch_words(input int k, input int n);
        int got;
        int t;
        got = 0;
        t = 0;
        while (got < n) begin
            @(negedge clk);
            t++;
            if (t > LIMIT) abort("fetch words missing");
            if (cmd_vld) check_true(!srv_rdy, "command accepted during fetch");
            if (srv_dat_vld && acc_rdy) begin
                check_true(isa_vld, "fetch word without isa_vld");
                check_word(srv_dat, ref_mem[fetch_addr(k)], "fetch word");
                exp_cnt[k]++;
                got++;
            end
            @(posedge clk);
            acc_rdy <= (got < n) ? (($urandom % 4) != 0) : 1'b0;
        end
    endtask

    // Unit k drops its line, the held word is thrown away
    task automatic end_fetch(input int k);
        int t;
        @(posedge clk);
        cfg_rdy[k] <= 1'b0;
        acc_rdy    <= 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > LIMIT) abort("fetch session never ended");
        end while (isa_vld);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        void'($urandom(32'h064012fa));
        rst_n       = 1'b0;
        cfg_rdy     = '0;
        cmd_vld     = 1'b0;
        acc_dat_vld = 1'b0;
        acc_dat     = '0;
        acc_rdy     = 1'b0;
        checks      = 0;
        errors      = 0;
        err_mark    = 0;
        for (int i = 0; i < 2**ADDR_W; i++) ref_mem[i] = '0;
        for (int i = 0; i < NUM_UNITS; i++) exp_cnt[i] = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Idle after reset
        repeat (6) begin
            @(negedge clk);
            check_true(!isa_vld && !srv_dat_vld && !srv_rdy, "output active while idle");
        end
        report("reset idle");

        write_burst(addr_t'(300), 20);
        read_burst(addr_t'(300), 20);
        report("write then read");

        read_burst(addr_t'(290), 45);
        report("read back-pressure");

        for (int k = 0; k < NUM_UNITS; k++) write_burst(addr_t'(k * 64), 24);
        @(posedge clk);
        cfg_rdy[2] <= 1'b1;
        fetch_words(2, 6);
        end_fetch(2);
        @(posedge clk);
        cfg_rdy[2] <= 1'b1;
        fetch_words(2, 5);
        end_fetch(2);
        report("fetch resume");

        @(posedge clk);
        cfg_rdy <= 4'b1010;
        fetch_words(1, 5);
        end_fetch(1);
        fetch_words(3, 5);
        end_fetch(3);
        report("fetch priority");

        @(posedge clk);
        cfg_rdy[0] <= 1'b1;
        fetch_words(0, 3);
        @(posedge clk);
        cmd_vld     <= 1'b1;
        acc_dat     <= make_cmd(1'b1, addr_t'(500), 12);
        acc_dat_vld <= 1'b1;
        fetch_words(0, 6);
        end_fetch(0);
        write_burst(addr_t'(500), 12);
        read_burst(addr_t'(500), 12);
        report("command waits for fetch");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
